// ==== verilog/chan_pkg.sv ====
package chan_pkg;

  // channel payload.
  localparam int DATA_W = 16;

  // receive buffer geometry.
  localparam int FIFO_AW    = 3;
  localparam int FIFO_DEPTH = 1 << FIFO_AW;           // also the upstream credit pool.
  localparam int USEDW_W    = FIFO_AW + 1;            // holds 0 to FIFO_DEPTH.

  // status thresholds on the used-word count.
  localparam logic [USEDW_W-1:0] ALMOST_FULL_LVL  = USEDW_W'(6);  // set at or above.
  localparam logic [USEDW_W-1:0] ALMOST_EMPTY_LVL = USEDW_W'(2);  // set below.

  // egress credit counter.
  localparam int                  CREDIT_W   = 4;
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(15);     // saturation value.

  // drain FSM state codes.
  localparam int DRAIN_STATE_W = 2;

  localparam logic [DRAIN_STATE_W-1:0] DRAIN_IDLE = 2'd0;  // buffer empty.
  localparam logic [DRAIN_STATE_W-1:0] DRAIN_SEND = 2'd1;  // data and credit seen.
  localparam logic [DRAIN_STATE_W-1:0] DRAIN_WAIT = 2'd2;  // data held back, no credit.

endpackage

// ==== verilog/buf_mem.sv ====
`timescale 1ns/10ps

module buf_mem
  import chan_pkg::*;
(
  input  logic               clk_i,

  input  logic               wr_en_i,
  input  logic [FIFO_AW-1:0] wr_addr_i,
  input  logic [DATA_W-1:0]  wr_data_i,

  input  logic [FIFO_AW-1:0] rd_addr_i,
  output logic [DATA_W-1:0]  rd_data_o
);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];

  always_ff @(posedge clk_i)
    begin
      if (wr_en_i)
        begin
          mem[wr_addr_i] <= wr_data_i;
        end
    end

  // read every cycle so the FIFO can steer the address to prefetch the head.
  // a read of the address written at the same edge returns the old word.
  always_ff @(posedge clk_i)
    begin
      rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== verilog/fifo.sv ====
`timescale 1ns/10ps

module fifo
  import chan_pkg::*;
(
  input  logic               clk_i,
  input  logic               srst_i,

  input  logic               wr_en_i,
  input  logic [DATA_W-1:0]  wr_data_i,
  input  logic               rd_en_i,

  output logic [DATA_W-1:0]  q_o,
  output logic               empty_o,
  output logic               full_o,
  output logic [USEDW_W-1:0] usedw_o,
  output logic               almost_full_o,
  output logic               almost_empty_o,
  output logic               overflow_o
);

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW-1:0] mem_rd_addr;
  logic [USEDW_W-1:0] usedw_q;
  logic [USEDW_W-1:0] usedw_d;

  logic               wr_accept;
  logic               rd_accept;

  logic [DATA_W-1:0]  mem_q;
  logic               bypass_q;
  logic [DATA_W-1:0]  bypass_data_q;

  assign rd_accept = rd_en_i && !empty_o;                 // no pop from an empty buffer.
  assign wr_accept = wr_en_i && (!full_o || rd_accept);   // full only frees a slot on a pop.

  // on a pop fetch the entry behind the head for show-ahead.
  assign mem_rd_addr = rd_accept ? rd_ptr + 1'b1 : rd_ptr;

  buf_mem mem0 (
    .clk_i     (clk_i),
    .wr_en_i   (wr_accept),
    .wr_addr_i (wr_ptr),
    .wr_data_i (wr_data_i),
    .rd_addr_i (mem_rd_addr),
    .rd_data_o (mem_q)
  );

  // pointers wrap at the depth, which is a power of two.
  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        begin
          wr_ptr <= '0;
          rd_ptr <= '0;
        end
      else
        begin
          if (wr_accept)
            wr_ptr <= wr_ptr + 1'b1;
          if (rd_accept)
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

  // the new head is being written at this same edge, so the memory read
  // would return stale data. happens on a write into an empty buffer and
  // on a write plus pop with one word held.
  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        bypass_q <= 1'b0;
      else
        bypass_q <= wr_accept && (mem_rd_addr == wr_ptr);
    end

  always_ff @(posedge clk_i)
    begin
      bypass_data_q <= wr_data_i;                         // word that skips the memory.
    end

  assign q_o = bypass_q ? bypass_data_q : mem_q;

  always_comb
    begin
      usedw_d = usedw_q;
      if (wr_accept && !rd_accept)
        usedw_d = usedw_q + 1'b1;
      else if (rd_accept && !wr_accept)
        usedw_d = usedw_q - 1'b1;
    end

  // flags are registered from the next count so they move with it.
  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        begin
          usedw_q        <= '0;
          empty_o        <= 1'b1;
          full_o         <= 1'b0;
          almost_full_o  <= 1'b0;
          almost_empty_o <= 1'b1;
        end
      else
        begin
          usedw_q        <= usedw_d;
          empty_o        <= (usedw_d == '0);
          full_o         <= (usedw_d == USEDW_W'(FIFO_DEPTH));
          almost_full_o  <= (usedw_d >= ALMOST_FULL_LVL);
          almost_empty_o <= (usedw_d < ALMOST_EMPTY_LVL);
        end
    end

  assign usedw_o = usedw_q;

  // sticky until reset. the dropped word never reaches memory.
  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        overflow_o <= 1'b0;
      else if (wr_en_i && !wr_accept)
        overflow_o <= 1'b1;
    end

endmodule

// ==== verilog/credit_counter.sv ====
`timescale 1ns/10ps

module credit_counter
  import chan_pkg::*;
(
  input  logic clk_i,
  input  logic srst_i,

  input  logic grant_i,         // one pulse per slot granted downstream.
  input  logic spend_i,         // one pulse per word delivered.

  output logic credit_avail_o
);

  logic [CREDIT_W-1:0] count_q;
  logic [CREDIT_W-1:0] count_d;

  always_comb
    begin
      count_d = count_q;
      if (grant_i && !spend_i)
        begin
          if (count_q != CREDIT_MAX)
            count_d = count_q + 1'b1;                     // extra grants are lost at the top.
        end
      else if (spend_i && !grant_i)
        begin
          if (count_q != '0)
            count_d = count_q - 1'b1;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        count_q <= '0;
      else
        count_q <= count_d;
    end

  // a spend in this cycle is already reflected in the next one.
  assign credit_avail_o = (count_q != '0);

endmodule

// ==== verilog/drain_fsm.sv ====
`timescale 1ns/10ps

module drain_fsm
  import chan_pkg::*;
(
  input  logic              clk_i,
  input  logic              srst_i,

  input  logic              fifo_empty_i,
  input  logic [DATA_W-1:0] head_data_i,
  input  logic              credit_avail_i,

  output logic              pop_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o,
  output logic              in_credit_o
);

  logic [DRAIN_STATE_W-1:0] state_q;
  logic [DRAIN_STATE_W-1:0] state_d;

  // state records what the previous cycle looked like; the pop itself is
  // decided in the current cycle so a fresh word can leave right away.
  always_comb
    begin
      pop_o   = 1'b0;
      state_d = DRAIN_IDLE;
      case (state_q)
        DRAIN_IDLE, DRAIN_SEND:
          begin
            pop_o = !fifo_empty_i && credit_avail_i;
            if (fifo_empty_i)
              state_d = DRAIN_IDLE;
            else if (credit_avail_i)
              state_d = DRAIN_SEND;
            else
              state_d = DRAIN_WAIT;
          end
        DRAIN_WAIT:
          begin
            // nothing was popped since data was seen, so the head is still there.
            pop_o = credit_avail_i;
            if (credit_avail_i)
              state_d = DRAIN_SEND;
            else
              state_d = DRAIN_WAIT;
          end
        default:
          begin
            pop_o   = 1'b0;
            state_d = DRAIN_IDLE;                         // recover from an unused code.
          end
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        state_q <= DRAIN_IDLE;
      else
        state_q <= state_d;
    end

  // the head word leaves with the pop, and its slot goes back upstream.
  assign out_valid_o = pop_o;
  assign out_data_o  = head_data_i;
  assign in_credit_o = pop_o;

endmodule

// ==== verilog/credit_chan_top.sv ====
`timescale 1ns/10ps

module credit_chan_top
  import chan_pkg::*;
(
  input  logic               clk_i,
  input  logic               srst_i,

  input  logic               in_valid_i,
  input  logic [DATA_W-1:0]  in_data_i,
  output logic               in_credit_o,

  input  logic               out_credit_i,
  output logic               out_valid_o,
  output logic [DATA_W-1:0]  out_data_o,

  output logic [USEDW_W-1:0] usedw_o,
  output logic               almost_full_o,
  output logic               almost_empty_o,
  output logic               overflow_o
);

  logic              fifo_empty;
  logic [DATA_W-1:0] fifo_head;
  logic              pop;
  logic              credit_avail;

  fifo fifo0 (
    .clk_i          (clk_i),
    .srst_i         (srst_i),
    .wr_en_i        (in_valid_i),
    .wr_data_i      (in_data_i),
    .rd_en_i        (pop),
    .q_o            (fifo_head),
    .empty_o        (fifo_empty),
    .full_o         (),                                  // full is seen as overflow only.
    .usedw_o        (usedw_o),
    .almost_full_o  (almost_full_o),
    .almost_empty_o (almost_empty_o),
    .overflow_o     (overflow_o)
  );

  credit_counter credit0 (
    .clk_i          (clk_i),
    .srst_i         (srst_i),
    .grant_i        (out_credit_i),
    .spend_i        (pop),                                // every pop is a delivery.
    .credit_avail_o (credit_avail)
  );

  drain_fsm drain0 (
    .clk_i          (clk_i),
    .srst_i         (srst_i),
    .fifo_empty_i   (fifo_empty),
    .head_data_i    (fifo_head),
    .credit_avail_i (credit_avail),
    .pop_o          (pop),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o),
    .in_credit_o    (in_credit_o)
  );

endmodule

// ==== bench/tb_credit_chan.sv ====
`timescale 1ns/10ps

module tb_credit_chan
  import chan_pkg::*;
();

  localparam int CLK_HALF_NS   = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int TOTAL_WORDS   = 2000;
  localparam int WATCHDOG_NS   = TOTAL_WORDS * 40 * 2 * CLK_HALF_NS;  // 40 cycles per word.
  localparam int SETTLE_CYCLES = 20;
  localparam int SEND_PCT      = 60;
  localparam int BURST_PCT     = 85;
  localparam int SLOW_PCT      = 8;

  localparam logic [DATA_W-1:0] DROP_WORD = 16'hdead;       // written beyond the credit rule.

  logic               clk_i = 1'b0;
  logic               srst_i;
  logic               in_valid_i;
  logic [DATA_W-1:0]  in_data_i;
  logic               in_credit_o;
  logic               out_credit_i;
  logic               out_valid_o;
  logic [DATA_W-1:0]  out_data_o;
  logic [USEDW_W-1:0] usedw_o;
  logic               almost_full_o;
  logic               almost_empty_o;
  logic               overflow_o;

  // reference of what the receive buffer holds.
  logic [DATA_W-1:0]  ref_q[$];
  logic [USEDW_W-1:0] exp_usedw;
  logic               exp_almost_full;
  logic               exp_almost_empty;
  logic               exp_overflow;

  int    up_credits;                                       // upstream sender model.
  int    outstanding;                                      // grants not yet used downstream.
  int    words_in;
  int    words_out;
  int    send_limit;
  bit    forced_wr;
  string test_name;

  credit_chan_top dut0 (
    .clk_i          (clk_i),
    .srst_i         (srst_i),
    .in_valid_i     (in_valid_i),
    .in_data_i      (in_data_i),
    .in_credit_o    (in_credit_o),
    .out_credit_i   (out_credit_i),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o),
    .usedw_o        (usedw_o),
    .almost_full_o  (almost_full_o),
    .almost_empty_o (almost_empty_o),
    .overflow_o     (overflow_o)
  );

  always #(CLK_HALF_NS) clk_i = ~clk_i;

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (exp !== act)
      begin
        $display("mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
        abort_run();
      end
  endtask

  task automatic check_count(input string what, input logic [USEDW_W-1:0] exp,
                             input logic [USEDW_W-1:0] act);
    if (exp !== act)
      begin
        $display("mismatch in %s: %s expected %0d actual %0d", test_name, what, exp, act);
        abort_run();
      end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act)
      begin
        $display("mismatch in %s: %s expected %b actual %b", test_name, what, exp, act);
        abort_run();
      end
  endtask

  // applies one clock edge to the reference buffer.
  function automatic void ref_step(input logic wr, input logic [DATA_W-1:0] wdata,
                                   input logic pop);
    int held;
    held = ref_q.size();
    if (pop && held > 0)
      void'(ref_q.pop_front());
    if (wr)
      begin
        if (held < FIFO_DEPTH || pop)
          ref_q.push_back(wdata);
        else
          exp_overflow = 1'b1;                             // dropped, never stored.
      end
    exp_usedw        = USEDW_W'(ref_q.size());
    exp_almost_full  = (exp_usedw >= ALMOST_FULL_LVL);
    exp_almost_empty = (exp_usedw < ALMOST_EMPTY_LVL);
  endfunction

  task automatic check_outputs();
    logic exp_valid;
    exp_valid = (ref_q.size() != 0) && (outstanding > 0);  // data held and credit granted.
    check_count("usedw_o", exp_usedw, usedw_o);
    check_flag("almost_full_o", exp_almost_full, almost_full_o);
    check_flag("almost_empty_o", exp_almost_empty, almost_empty_o);
    check_flag("overflow_o", exp_overflow, overflow_o);
    check_flag("out_valid_o", exp_valid, out_valid_o);
    check_flag("in_credit_o", exp_valid, in_credit_o);     // slot returns with the delivery.
    if (exp_valid)
      check_data("out_data_o", ref_q[0], out_data_o);
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    check_count("usedw_o", '0, usedw_o);
    check_flag("almost_empty_o", 1'b1, almost_empty_o);
    check_flag("almost_full_o", 1'b0, almost_full_o);
    check_flag("overflow_o", 1'b0, overflow_o);
    check_flag("out_valid_o", 1'b0, out_valid_o);
    check_flag("in_credit_o", 1'b0, in_credit_o);
    @(posedge clk_i);
    #1;
  endtask

  // checks mid cycle, books the coming edge, then drives the next inputs.
  task automatic run_cycle(input int send_pct, input int grant_pct, input bit force_wr);
    int roll;
    @(negedge clk_i);
    check_outputs();
    ref_step(in_valid_i, in_data_i, out_valid_o);
    if (in_valid_i && !forced_wr)
      begin
        up_credits = up_credits - 1;
        words_in   = words_in + 1;
      end
    if (in_credit_o)
      up_credits = up_credits + 1;
    if (out_credit_i)
      outstanding = outstanding + 1;
    if (out_valid_o)
      begin
        outstanding = outstanding - 1;
        words_out   = words_out + 1;
      end
    if (up_credits < 0 || up_credits > FIFO_DEPTH)
      begin
        $display("%s: upstream credit count left its range, now %0d", test_name, up_credits);
        abort_run();
      end
    @(posedge clk_i);
    #1;
    forced_wr = force_wr;
    if (force_wr)
      begin
        in_valid_i = 1'b1;
        in_data_i  = DROP_WORD;
      end
    else
      begin
        roll       = $urandom_range(99);
        in_valid_i = (up_credits > 0) && (words_in < send_limit) && (roll < send_pct);
        in_data_i  = DATA_W'($urandom);
      end
    roll         = $urandom_range(99);
    out_credit_i = (outstanding < int'(CREDIT_MAX)) && (roll < grant_pct);  // no saturation.
  endtask

  initial
    begin : watchdog
      #(WATCHDOG_NS);
      $display("run timed out after %0d ns without finishing the tests", WATCHDOG_NS);
      abort_run();
    end

  initial
    begin : main
      void'($urandom(32'h430e));
      srst_i       = 1'b1;
      in_valid_i   = 1'b0;
      in_data_i    = '0;
      out_credit_i = 1'b0;
      forced_wr    = 1'b0;
      up_credits   = FIFO_DEPTH;
      outstanding  = 0;
      words_in     = 0;
      words_out    = 0;
      send_limit   = TOTAL_WORDS;
      exp_overflow = 1'b0;
      ref_q.delete();
      ref_step(1'b0, '0, 1'b0);

      test_name = "reset_state";
      repeat (RESET_CYCLES) @(posedge clk_i);
      #1;
      srst_i = 1'b0;
      check_reset_state();

      // grants alternate between bursts and a trickle every 250 words.
      test_name = "order_data";
      while (words_out < TOTAL_WORDS)
        run_cycle(SEND_PCT, ((words_out / 250) % 2 == 0) ? BURST_PCT : SLOW_PCT, 1'b0);

      test_name  = "no_grant_fill";
      send_limit = 2 * TOTAL_WORDS;
      while (!(ref_q.size() == FIFO_DEPTH && outstanding == 0))
        run_cycle(SEND_PCT, 0, 1'b0);
      repeat (SETTLE_CYCLES)
        run_cycle(SEND_PCT, 0, 1'b0);
      if (up_credits != 0)
        begin
          $display("%s: upstream still holds %0d credits with the buffer full",
                   test_name, up_credits);
          abort_run();
        end

      test_name = "overflow";
      run_cycle(0, 0, 1'b1);
      repeat (SETTLE_CYCLES)
        run_cycle(0, 0, 1'b0);
      while (ref_q.size() != 0)
        run_cycle(0, 50, 1'b0);
      repeat (SETTLE_CYCLES)
        run_cycle(0, 50, 1'b0);
      @(negedge clk_i);
      check_outputs();
      check_flag("overflow_o", 1'b1, overflow_o);          // still sticky after the drain.

      $display("sim passed");
      $finish;
    end

endmodule

// ==== build.f ====
verilog/chan_pkg.sv
verilog/buf_mem.sv
verilog/fifo.sv
verilog/credit_counter.sv
verilog/drain_fsm.sv
verilog/credit_chan_top.sv
bench/tb_credit_chan.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the channel testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

TOP=tb_credit_chan
OBJ_DIR=obj_dir

verilator --binary --timing --top-module "$TOP" --Mdir "$OBJ_DIR" -f build.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

output=$("./$OBJ_DIR/V$TOP" 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^sim passed$"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
